// File: flist.f
+incdir+include
src/mandel_pkg.sv
src/pix_link_if.sv
src/view_ctrl.sv
src/scan_gen.sv
src/iter_engine.sv
src/shade_map.sv
src/mandel_top.sv
testbench/tb_mandel_top.sv

// File: include/mandel_cfg.svh
// ==============================
// frame size, fixed-point format, iteration limit
// start view, credit depths and colour scheme
// ==============================
`ifndef MANDEL_CFG_SVH
`define MANDEL_CFG_SVH

// frame
`define MANDEL_FB_W          16            // pixels per row
`define MANDEL_FB_H          8             // rows per frame

// fixed point
`define MANDEL_FP_W          25            // total bits
`define MANDEL_FP_INT        4             // integer bits so 21 fraction bits
`define MANDEL_ITER_MAX      31            // escape-time limit

// start view in fixed point
`define MANDEL_X_START       25'h1B00000   // -2.5
`define MANDEL_Y_START       25'h1E00000   // -1.0
`define MANDEL_STEP          25'h0080000   // 0.25 and largest step allowed

// flow control
`define MANDEL_LINK_CREDITS  2             // receiver buffer depth
`define MANDEL_OUT_CREDITS   4             // credits granted by the consumer

`define MANDEL_COLR_SCHEME   1             // 1 blue-green, 0 blue-purple-gold

`endif

// File: src/iter_engine.sv
// ==============================
// input buffer and escape-time iteration
// ==============================
`timescale 1ns/1ps
`include "mandel_cfg.svh"

module iter_engine (
    input  logic          clk_sys,
    input  logic          rst_sys,
    pix_link_if.receiver  pix_in,
    pix_link_if.sender    pix_out
);
    import mandel_pkg::*;

    localparam int FRAC  = `MANDEL_FP_W - `MANDEL_FP_INT;
    localparam int PW    = 2 * `MANDEL_FP_W;  // full product width
    localparam int DEPTH = `MANDEL_LINK_CREDITS;
    localparam int AW    = $clog2(DEPTH);
    localparam int CW    = $clog2(DEPTH + 1);
    localparam logic signed [PW:0] FOUR = 4 <<< FRAC;

    coord_t  buf_x  [DEPTH];
    coord_t  buf_y  [DEPTH];
    fp_t     buf_cr [DEPTH];
    fp_t     buf_ci [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic [CW-1:0] credits;  // downstream
    logic    pop;
    logic    emit;
    logic    escape;
    logic    loaded;         // pixel in the engine
    logic    done;           // count final, waiting for credit
    coord_t  px;
    coord_t  py;
    fp_t     cr;
    fp_t     ci;
    fp_t     zr;
    fp_t     zi;
    iter_t   n;
    logic signed [PW-1:0] zr2;
    logic signed [PW-1:0] zi2;
    logic signed [PW-1:0] zri;
    logic signed [PW-1:0] zr_nx;
    logic signed [PW-1:0] zi_nx;
    logic signed [PW:0]   mag;  // |z| squared

    assign pop  = !loaded && (count != '0);
    assign emit = done && (credits != '0);
    assign pix_out.cr = '0;  // not carried downstream
    assign pix_out.ci = '0;

    always_comb begin
        zr2    = (zr * zr) >>> FRAC;
        zi2    = (zi * zi) >>> FRAC;
        zri    = (zr * zi) >>> FRAC;
        mag    = zr2 + zi2;
        zr_nx  = zr2 - zi2 + cr;
        zi_nx  = (zri <<< 1) + ci;
        escape = (n == iter_t'(`MANDEL_ITER_MAX)) || (mag > FOUR);
    end

    always_ff @(posedge clk_sys) begin
        if (pix_in.valid) begin
            buf_x[wr_ptr]  <= pix_in.x;
            buf_y[wr_ptr]  <= pix_in.y;
            buf_cr[wr_ptr] <= pix_in.cr;
            buf_ci[wr_ptr] <= pix_in.ci;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            pix_in.credit <= 1'b0;
            credits       <= CW'(DEPTH);
            pix_out.valid <= 1'b0;
            loaded        <= 1'b0;
            done          <= 1'b0;
        end else begin
            if (pix_in.valid) wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)          rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count         <= count + CW'(pix_in.valid) - CW'(pop);
            pix_in.credit <= pop;  // slot freed
            credits       <= credits - CW'(emit) + CW'(pix_out.credit);
            pix_out.valid <= emit;
            if (pop) begin
                loaded <= 1'b1;
                done   <= 1'b0;
            end else if (emit) begin
                loaded <= 1'b0;
                done   <= 1'b0;
            end else if (loaded && !done && escape) begin
                done <= 1'b1;
            end
        end
    end

    // one iteration per cycle
    always_ff @(posedge clk_sys) begin
        if (pop) begin
            px <= buf_x[rd_ptr];
            py <= buf_y[rd_ptr];
            cr <= buf_cr[rd_ptr];
            ci <= buf_ci[rd_ptr];
            zr <= '0;
            zi <= '0;
            n  <= '0;
        end else if (loaded && !done && !escape) begin
            zr <= zr_nx[`MANDEL_FP_W-1:0];  // truncate
            zi <= zi_nx[`MANDEL_FP_W-1:0];
            n  <= n + 1'b1;
        end
        if (emit) begin
            pix_out.x    <= px;
            pix_out.y    <= py;
            pix_out.iter <= n;
        end
    end

endmodule

// File: src/mandel_pkg.sv
// ==============================
// fixed-point, coordinate, count and view types
// ==============================
`include "mandel_cfg.svh"

package mandel_pkg;

    typedef logic signed [`MANDEL_FP_W-1:0] fp_t;  // signed Q4.21
    typedef logic [4:0] coord_t;                   // pixel x or y
    typedef logic [4:0] iter_t;                    // escape count
    typedef logic [7:0] cidx_t;                    // colour index

    // view parameters for one render
    typedef struct packed {
        fp_t x_start;  // left edge
        fp_t y_start;  // top edge
        fp_t step;     // distance between pixels
    } view_t;

endpackage

// File: src/mandel_top.sv
// ==============================
// mandelbrot renderer top level
// ==============================
`timescale 1ns/1ps

module mandel_top (
    input  logic               clk_sys,
    input  logic               rst_sys,
    input  logic               btn_mode,
    input  logic               btn_up,
    input  logic               btn_dn,
    input  logic               out_credit,  // one per consumed pixel
    output logic               out_valid,
    output mandel_pkg::coord_t out_x,
    output mandel_pkg::coord_t out_y,
    output logic [7:0]         out_r,
    output logic [7:0]         out_g,
    output logic [7:0]         out_b
);
    import mandel_pkg::*;

    view_t view;   // committed view
    logic  start;  // render request
    logic  busy;   // scan in progress

    pix_link_if scan_link ();  // scan to iteration
    pix_link_if iter_link ();  // iteration to shading

    view_ctrl u_view_ctrl (
        .clk_sys,
        .rst_sys,
        .btn_mode,
        .btn_up,
        .btn_dn,
        .busy,
        .start,
        .view
    );

    scan_gen u_scan_gen (
        .clk_sys,
        .rst_sys,
        .start,
        .view,
        .busy,
        .pix     (scan_link.sender)
    );

    iter_engine u_iter_engine (
        .clk_sys,
        .rst_sys,
        .pix_in  (scan_link.receiver),
        .pix_out (iter_link.sender)
    );

    shade_map u_shade_map (
        .clk_sys,
        .rst_sys,
        .pix_in  (iter_link.receiver),
        .out_credit,
        .out_valid,
        .out_x,
        .out_y,
        .out_r,
        .out_g,
        .out_b
    );

endmodule

// File: src/pix_link_if.sv
// ==============================
// credited pixel link between stages
// ==============================
`timescale 1ns/1ps

interface pix_link_if;
    import mandel_pkg::*;

    logic   valid;   // one item this cycle
    coord_t x;       // pixel column
    coord_t y;       // pixel row
    fp_t    cr;      // real part of c
    fp_t    ci;      // imaginary part of c
    iter_t  iter;    // escape count
    logic   credit;  // receiver popped one entry

    modport sender (
        output valid,
        output x,
        output y,
        output cr,
        output ci,
        output iter,
        input  credit
    );

    modport receiver (
        input  valid,
        input  x,
        input  y,
        input  cr,
        input  ci,
        input  iter,
        output credit
    );

endinterface

// File: src/scan_gen.sv
// ==============================
// raster scan with pixel coordinates
// ==============================
`timescale 1ns/1ps
`include "mandel_cfg.svh"

module scan_gen (
    input  logic              clk_sys,
    input  logic              rst_sys,
    input  logic              start,  // begin a frame
    input  mandel_pkg::view_t view,
    output logic              busy,   // frame still being issued
    pix_link_if.sender        pix
);
    import mandel_pkg::*;

    localparam int CW = $clog2(`MANDEL_LINK_CREDITS + 1);

    logic [CW-1:0] credits;
    logic          issue;
    logic          row_end;
    logic          last;
    coord_t        x_cnt;
    coord_t        y_cnt;
    fp_t           x0;      // row restart value
    fp_t           step;
    fp_t           cr_acc;  // running x_start + x*step
    fp_t           ci_acc;  // running y_start + y*step

    assign issue   = busy && (credits != '0);
    assign row_end = (x_cnt == coord_t'(`MANDEL_FB_W - 1));
    assign last    = row_end && (y_cnt == coord_t'(`MANDEL_FB_H - 1));
    assign pix.iter = '0;  // not carried on this link

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            busy      <= 1'b0;
            pix.valid <= 1'b0;
            credits   <= CW'(`MANDEL_LINK_CREDITS);
            x_cnt     <= '0;
            y_cnt     <= '0;
        end else begin
            pix.valid <= issue;
            credits   <= credits - CW'(issue) + CW'(pix.credit);  // spend and return
            if (start) begin
                busy  <= 1'b1;
                x_cnt <= '0;
                y_cnt <= '0;
            end else if (issue) begin
                x_cnt <= row_end ? '0 : x_cnt + 1'b1;
                if (row_end) y_cnt <= y_cnt + 1'b1;
                if (last) busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (start) begin
            x0     <= view.x_start;
            step   <= view.step;
            cr_acc <= view.x_start;
            ci_acc <= view.y_start;
        end else if (issue) begin
            pix.x  <= x_cnt;
            pix.y  <= y_cnt;
            pix.cr <= cr_acc;
            pix.ci <= ci_acc;
            if (row_end) begin  // back to left edge, next row
                cr_acc <= x0;
                ci_acc <= ci_acc + step;
            end else begin
                cr_acc <= cr_acc + step;
            end
        end
    end

endmodule

// File: src/shade_map.sv
// ==============================
// input buffer, colour mapping, output credits
// ==============================
`timescale 1ns/1ps
`include "mandel_cfg.svh"

module shade_map (
    input  logic               clk_sys,
    input  logic               rst_sys,
    pix_link_if.receiver       pix_in,
    input  logic               out_credit,  // consumer took a pixel
    output logic               out_valid,
    output mandel_pkg::coord_t out_x,
    output mandel_pkg::coord_t out_y,
    output logic [7:0]         out_r,
    output logic [7:0]         out_g,
    output logic [7:0]         out_b
);
    import mandel_pkg::*;

    localparam int DEPTH = `MANDEL_LINK_CREDITS;
    localparam int AW    = $clog2(DEPTH);
    localparam int CW    = $clog2(DEPTH + 1);
    localparam int OCW   = $clog2(`MANDEL_OUT_CREDITS + 1);

    coord_t  buf_x  [DEPTH];
    coord_t  buf_y  [DEPTH];
    iter_t   buf_it [DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic [CW-1:0]  count;
    logic [OCW-1:0] credits;  // output side
    logic    pop;
    cidx_t   idx;
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;

    assign pop = (count != '0) && (credits != '0);

    always_comb begin
        idx = (buf_it[rd_ptr] == iter_t'(`MANDEL_ITER_MAX)) ? '0 : cidx_t'(buf_it[rd_ptr]) << 3;
        if (`MANDEL_COLR_SCHEME != 0) begin  // blue-green
            r = idx >> 1;
            g = idx;
            b = idx;
        end else if (idx == '0) begin      // black in the set
            r = '0;
            g = '0;
            b = '0;
        end else if (idx <= 8'h66) begin   // blue into purple
            r = idx;
            g = idx >> 1;
            b = 8'h33 + idx;
        end else begin                     // toward gold
            r = idx;
            g = idx - 8'h33;
            b = 8'hFF - idx;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (pix_in.valid) begin
            buf_x[wr_ptr]  <= pix_in.x;
            buf_y[wr_ptr]  <= pix_in.y;
            buf_it[wr_ptr] <= pix_in.iter;
        end
        if (pop) begin
            out_x <= buf_x[rd_ptr];
            out_y <= buf_y[rd_ptr];
            out_r <= r;
            out_g <= g;
            out_b <= b;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            pix_in.credit <= 1'b0;
            credits       <= OCW'(`MANDEL_OUT_CREDITS);
            out_valid     <= 1'b0;
        end else begin
            if (pix_in.valid) wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)          rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count         <= count + CW'(pix_in.valid) - CW'(pop);
            pix_in.credit <= pop;
            credits       <= credits - OCW'(pop) + OCW'(out_credit);
            out_valid     <= pop;  // one cycle after the head is taken
        end
    end

endmodule

// File: src/view_ctrl.sv
// ==============================
// view controller FSM
// pan, zoom, zoom limit and render start
// ==============================
`timescale 1ns/1ps
`include "mandel_cfg.svh"

module view_ctrl (
    input  logic              clk_sys,
    input  logic              rst_sys,
    input  logic              btn_mode,  // next mode
    input  logic              btn_up,    // left, up or zoom out
    input  logic              btn_dn,    // right, down or zoom in
    input  logic              busy,      // scan in progress
    output logic              start,     // one pulse per committed view
    output mandel_pkg::view_t view
);
    import mandel_pkg::*;

    typedef enum logic [1:0] {M_HORZ, M_VERT, M_ZOOM} mode_t;

    mode_t mode;
    mode_t mode_nx;
    view_t view_p;      // proposed view, checked next cycle
    view_t prop;
    logic  want;        // a button asks for a change
    logic  changed;     // proposal waiting for check
    logic  render_req;  // committed view waiting for start
    logic  idle;

    // buttons only count with nothing in flight
    assign idle = !busy && !changed && !render_req && !start;

    always_comb begin
        case (mode)
            M_HORZ:  mode_nx = M_VERT;
            M_VERT:  mode_nx = M_ZOOM;
            default: mode_nx = M_HORZ;
        endcase
    end

    // pan and zoom arithmetic
    always_comb begin
        prop = view;
        want = btn_up || btn_dn;
        case (mode)
            M_HORZ: begin
                if (btn_up) prop.x_start = view.x_start - (view.step <<< 4);  // left
                else        prop.x_start = view.x_start + (view.step <<< 4);  // right
            end
            M_VERT: begin
                if (btn_up) prop.y_start = view.y_start - (view.step <<< 4);
                else        prop.y_start = view.y_start + (view.step <<< 4);
            end
            M_ZOOM: begin
                if (btn_up) begin  // zoom out about the centre
                    prop.x_start = view.x_start - (view.step <<< 7);
                    prop.y_start = view.y_start - (view.step <<< 6) - (view.step <<< 5);
                    prop.step    = view.step <<< 1;
                end else begin     // zoom in
                    prop.x_start = view.x_start + (view.step <<< 6);
                    prop.y_start = view.y_start + (view.step <<< 5) + (view.step <<< 4);
                    prop.step    = view.step >>> 1;
                end
            end
            default: want = 1'b0;
        endcase
    end

    always_ff @(posedge clk_sys) begin
        if (idle && want) view_p <= prop;
    end

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            mode       <= M_HORZ;
            view       <= '{x_start: `MANDEL_X_START,
                            y_start: `MANDEL_Y_START,
                            step:    `MANDEL_STEP};
            changed    <= 1'b0;
            render_req <= 1'b1;  // first frame after reset
            start      <= 1'b0;
        end else begin
            start <= 1'b0;
            if (idle) begin
                if (want) changed <= 1'b1;
                if (btn_mode) mode <= mode_nx;
            end
            if (changed) begin
                changed <= 1'b0;
                // zoom limits, a rejected view is just dropped
                if (view_p.step != '0 && view_p.step <= fp_t'(`MANDEL_STEP)) begin
                    view       <= view_p;
                    render_req <= 1'b1;
                end
            end else if (render_req) begin
                start      <= 1'b1;
                render_req <= 1'b0;
            end
        end
    end

endmodule

// File: testbench/tb_mandel_top.sv
// ==============================
// testbench for the mandelbrot renderer
// action table, reference model, credit return
// ==============================
`timescale 1ns/1ps
`include "mandel_cfg.svh"

module tb_mandel_top;
    import mandel_pkg::*;

    localparam int NPIX         = `MANDEL_FB_W * `MANDEL_FB_H;
    localparam int FRAC         = `MANDEL_FP_W - `MANDEL_FP_INT;
    localparam int PIX_TIMEOUT  = 2000;  // cycles allowed per pixel
    localparam int QUIET_CYCLES = 300;   // window with no pixel expected
    localparam int HOLD_CYCLES  = 200;   // credits held back mid-frame
    localparam int MAX_ROWS     = 16;

    typedef enum logic [1:0] {ACT_NONE, ACT_MODE, ACT_UP, ACT_DN} act_t;

    logic       clk_sys    = 1'b0;
    logic       rst_sys    = 1'b1;
    logic       btn_mode   = 1'b0;
    logic       btn_up     = 1'b0;
    logic       btn_dn     = 1'b0;
    logic       out_credit = 1'b0;
    logic       out_valid;
    coord_t     out_x;
    coord_t     out_y;
    logic [7:0] out_r;
    logic [7:0] out_g;
    logic [7:0] out_b;

    // action table
    string row_name   [MAX_ROWS];
    act_t  row_act    [MAX_ROWS];
    bit    row_frame  [MAX_ROWS];  // frame expected
    bit    row_glitch [MAX_ROWS];  // buttons pressed mid-frame
    fp_t   row_xs     [MAX_ROWS];
    fp_t   row_ys     [MAX_ROWS];
    fp_t   row_st     [MAX_ROWS];
    int    n_rows = 0;

    logic [7:0] exp_r [NPIX];      // model colours for one frame
    logic [7:0] exp_g [NPIX];
    logic [7:0] exp_b [NPIX];

    coord_t     rx_x [$];          // received pixels
    coord_t     rx_y [$];
    logic [7:0] rx_r [$];
    logic [7:0] rx_g [$];
    logic [7:0] rx_b [$];
    int         due_q [$];         // cycle at which each credit goes back

    int cycle      = 0;
    int hold_until = 0;            // no credit returned before this cycle
    int sent_total = 0;            // pixels seen on the output
    int returned   = 0;            // credits given back
    int mismatches = 0;
    int proto_errs = 0;
    int timeouts   = 0;
    bit abort      = 1'b0;

    mandel_top u_mandel_top (
        .clk_sys,
        .rst_sys,
        .btn_mode,
        .btn_up,
        .btn_dn,
        .out_credit,
        .out_valid,
        .out_x,
        .out_y,
        .out_r,
        .out_g,
        .out_b
    );

    always #2 clk_sys = ~clk_sys;  // 4 ns period

    // output sink sampled on the falling edge
    always @(negedge clk_sys) begin
        cycle++;
        if (!rst_sys && out_valid === 1'b1) begin
            rx_x.push_back(out_x);
            rx_y.push_back(out_y);
            rx_r.push_back(out_r);
            rx_g.push_back(out_g);
            rx_b.push_back(out_b);
            sent_total++;
            if (sent_total > `MANDEL_OUT_CREDITS + returned) begin
                proto_errs++;
                $display("out_valid rose with no output credit left (sent %0d, granted %0d)",
                         sent_total, `MANDEL_OUT_CREDITS + returned);
            end
            due_q.push_back(cycle + $urandom_range(3, 0));  // 0 to 3 cycles later
        end
        if (cycle >= hold_until && due_q.size() != 0 && due_q[0] <= cycle) begin
            void'(due_q.pop_front());
            out_credit = 1'b1;
            returned++;
        end else begin
            out_credit = 1'b0;
        end
    end

    task automatic add_row(input string name, input act_t act, input bit frame,
                           input bit glitch, input fp_t xs, input fp_t ys, input fp_t st);
        row_name[n_rows]   = name;
        row_act[n_rows]    = act;
        row_frame[n_rows]  = frame;
        row_glitch[n_rows] = glitch;
        row_xs[n_rows]     = xs;
        row_ys[n_rows]     = ys;
        row_st[n_rows]     = st;
        n_rows++;
    endtask

    // escape-time count from the iteration rule
    function automatic iter_t ref_iter(input fp_t cr, input fp_t ci);
        fp_t    zr;
        fp_t    zi;
        longint sr;
        longint si;
        longint sri;
        int     n;
        bit     fin;
        zr  = '0;
        zi  = '0;
        n   = 0;
        fin = 1'b0;
        while (!fin) begin
            if (n == `MANDEL_ITER_MAX) begin
                fin = 1'b1;
            end else begin
                sr  = (longint'(zr) * longint'(zr)) >>> FRAC;
                si  = (longint'(zi) * longint'(zi)) >>> FRAC;
                sri = (longint'(zr) * longint'(zi)) >>> FRAC;
                if (sr + si > (longint'(4) <<< FRAC)) begin
                    fin = 1'b1;  // escaped
                end else begin
                    zr = fp_t'(sr - si + longint'(cr));  // keep low 25 bits
                    zi = fp_t'((sri <<< 1) + longint'(ci));
                    n++;
                end
            end
        end
        return iter_t'(n);
    endfunction

    task automatic shade_ref(input iter_t it, output logic [7:0] r,
                             output logic [7:0] g, output logic [7:0] b);
        cidx_t idx;
        idx = (it == iter_t'(`MANDEL_ITER_MAX)) ? 8'h00 : {it, 3'b000};
        if (`MANDEL_COLR_SCHEME != 0) begin
            r = idx >> 1;
            g = idx;
            b = idx;
        end else if (idx == 8'h00) begin
            r = 8'h00;
            g = 8'h00;
            b = 8'h00;
        end else if (idx <= 8'h66) begin
            r = idx;
            g = idx >> 1;
            b = 8'h33 + idx;
        end else begin
            r = idx;
            g = idx - 8'h33;
            b = 8'hFF - idx;
        end
    endtask

    task automatic model_frame(input fp_t xs, input fp_t ys, input fp_t st);
        fp_t cr;
        fp_t ci;
        int  k;
        for (k = 0; k < NPIX; k++) begin
            cr = fp_t'(longint'(xs) + longint'(k % `MANDEL_FB_W) * longint'(st));
            ci = fp_t'(longint'(ys) + longint'(k / `MANDEL_FB_W) * longint'(st));
            shade_ref(ref_iter(cr, ci), exp_r[k], exp_g[k], exp_b[k]);
        end
    endtask

    task automatic pulse_buttons(input logic m, input logic u, input logic d);
        @(negedge clk_sys);
        btn_mode = m;
        btn_up   = u;
        btn_dn   = d;
        @(negedge clk_sys);  // single-cycle pulse
        btn_mode = 1'b0;
        btn_up   = 1'b0;
        btn_dn   = 1'b0;
    endtask

    task automatic wait_pixel(output bit ok);
        int t;
        t = 0;
        while (rx_x.size() == 0 && t < PIX_TIMEOUT) begin
            @(posedge clk_sys);
            t++;
        end
        ok = (rx_x.size() != 0);
    endtask

    task automatic check_coord(input string name, input coord_t expv, input coord_t act);
        if (act !== expv) begin
            mismatches++;
            $display("MISMATCH %s expected %0d actual %0d", name, expv, act);
        end
    endtask

    task automatic check_colour(input string name, input logic [7:0] expv,
                                input logic [7:0] act);
        if (act !== expv) begin
            mismatches++;
            $display("MISMATCH %s expected 0x%02h actual 0x%02h", name, expv, act);
        end
    endtask

    task automatic check_pixel(input string name, input int k);
        string tag;
        tag = $sformatf("%s pixel %0d", name, k);
        check_coord({tag, " x"}, coord_t'(k % `MANDEL_FB_W), rx_x.pop_front());  // raster order
        check_coord({tag, " y"}, coord_t'(k / `MANDEL_FB_W), rx_y.pop_front());
        check_colour({tag, " r"}, exp_r[k], rx_r.pop_front());
        check_colour({tag, " g"}, exp_g[k], rx_g.pop_front());
        check_colour({tag, " b"}, exp_b[k], rx_b.pop_front());
    endtask

    task automatic expect_quiet(input string name);
        int t;
        t = 0;
        while (rx_x.size() == 0 && t < QUIET_CYCLES) begin
            @(posedge clk_sys);
            t++;
        end
        if (rx_x.size() != 0) begin
            proto_errs++;
            $display("unexpected pixel arrived after '%s' where no frame was due", name);
            rx_x.delete();
            rx_y.delete();
            rx_r.delete();
            rx_g.delete();
            rx_b.delete();
        end
    endtask

    initial begin
        int r;
        int k;
        bit ok;
        void'($urandom(18460));
        // views worked out by hand with 25-bit wrap
        add_row("reset view",       ACT_NONE, 1, 0, 25'h1B00000, 25'h1E00000, 25'h0080000);
        add_row("pan right",        ACT_DN,   1, 1, 25'h0300000, 25'h1E00000, 25'h0080000);
        add_row("pan left",         ACT_UP,   1, 0, 25'h1B00000, 25'h1E00000, 25'h0080000);
        add_row("select vertical",  ACT_MODE, 0, 0, '0, '0, '0);
        add_row("pan up",           ACT_UP,   1, 0, 25'h1B00000, 25'h1600000, 25'h0080000);
        add_row("pan down",         ACT_DN,   1, 0, 25'h1B00000, 25'h1E00000, 25'h0080000);
        add_row("pan down again",   ACT_DN,   1, 0, 25'h1B00000, 25'h0600000, 25'h0080000);
        add_row("select zoom",      ACT_MODE, 0, 0, '0, '0, '0);
        add_row("zoom in",          ACT_DN,   1, 0, 25'h1B00000, 25'h1E00000, 25'h0040000);
        add_row("zoom out",         ACT_UP,   1, 0, 25'h1B00000, 25'h0600000, 25'h0080000);
        add_row("zoom out refused", ACT_UP,   0, 0, '0, '0, '0);  // step 0.5 over limit
        add_row("zoom in again",    ACT_DN,   1, 0, 25'h1B00000, 25'h1E00000, 25'h0040000);
        repeat (2) @(negedge clk_sys);
        rst_sys = 1'b0;
        for (r = 0; r < n_rows && !abort; r++) begin
            case (row_act[r])
                ACT_MODE: pulse_buttons(1'b1, 1'b0, 1'b0);
                ACT_UP:   pulse_buttons(1'b0, 1'b1, 1'b0);
                ACT_DN:   pulse_buttons(1'b0, 1'b0, 1'b1);
                default:  ;
            endcase
            if (row_frame[r]) begin
                model_frame(row_xs[r], row_ys[r], row_st[r]);
                for (k = 0; k < NPIX && !abort; k++) begin
                    if (row_glitch[r] && k == 2) pulse_buttons(1'b1, 1'b0, 1'b1);  // while busy
                    if (k == NPIX / 2) hold_until = cycle + HOLD_CYCLES;  // drain output credits
                    wait_pixel(ok);
                    if (!ok) begin
                        timeouts++;
                        abort = 1'b1;
                        $display("timeout: frame '%s' stalled after %0d of %0d pixels",
                                 row_name[r], k, NPIX);
                    end else begin
                        check_pixel(row_name[r], k);
                    end
                end
            end else begin
                expect_quiet(row_name[r]);
            end
        end
        if (!abort) expect_quiet("last frame");  // nothing duplicated at the end
        $display("errors: mismatches=%0d protocol=%0d timeouts=%0d",
                 mismatches, proto_errs, timeouts);
        if (mismatches == 0 && proto_errs == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
